/* bench/tb_turfio_core.sv */
`include "turfio_defs.svh"

module tb_turfio_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int ACK_TIMEOUT   = 8;
    localparam int N_CTRL        = 24;
    localparam int N_UNMAPPED    = 8;
    localparam int N_TRIG_ROUNDS = 10;
    localparam int N_PPS_ROUNDS  = 10;
    localparam int N_SYNC_ROUNDS = 3;
    // Rough cycle cost per bus access and per queue round
    localparam int BUS_CYCLES    = 4;
    localparam int ROUND_CYCLES  = 110;
    localparam int SYNC_CYCLES   = 120;
    localparam int TEST_CYCLES   = RESET_CYCLES + 20
                                 + (N_CTRL * 2 + N_UNMAPPED + 4) * BUS_CYCLES
                                 + (N_TRIG_ROUNDS + N_PPS_ROUNDS + 1) * ROUND_CYCLES
                                 + (N_SYNC_ROUNDS + 1) * SYNC_CYCLES;
    localparam int WATCHDOG_NS   = 2 * TEST_CYCLES * CLK_PERIOD + 1000;

    // DUT ports
    logic                          sysclk_i;
    logic                          rst_n_i;
    logic                          wb_cyc_i;
    logic                          wb_stb_i;
    logic                          wb_we_i;
    logic [`TURFIO_WB_ADR_W-1:0]   wb_adr_i;
    logic [`TURFIO_WB_DAT_W-1:0]   wb_dat_i;
    logic [`TURFIO_WB_DAT_W/8-1:0] wb_sel_i;
    logic                          wb_ack_o;
    logic [`TURFIO_WB_DAT_W-1:0]   wb_dat_o;
    logic [`TURFIO_CMD_W-1:0]      command_i;
    logic                          command_valid_i;
    logic                          sync_o;
    logic                          pps_o;

    //////////////////////////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////////////////////////

    // Control register as the bus should see it
    logic [31:0] m_ctrl;
    // Clock counter value after the latest edge
    logic [47:0] m_count;
    // Commands seen at the last edge and acted on at the next
    logic        sync_pend;
    logic        pps_pend;
    logic        trig_pend;
    logic [14:0] trig_pend_time;
    logic [15:0] trig_mq[$];
    logic [15:0] pps_mq[$];
    logic        trig_movf;
    logic        pps_movf;
    logic [31:0] lfsr_q;

    turfio_core i_dut (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_sel_i        (wb_sel_i),
        .wb_ack_o        (wb_ack_o),
        .wb_dat_o        (wb_dat_o),
        .command_i       (command_i),
        .command_valid_i (command_valid_i),
        .sync_o          (sync_o),
        .pps_o           (pps_o)
    );

    always #(CLK_PERIOD / 2) sysclk_i = ~sysclk_i;

    // Model steps on the DUT edges and reads pre-edge inputs
    always @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            m_ctrl    = '0;
            m_count   = '0;
            sync_pend = 1'b0;
            pps_pend  = 1'b0;
            trig_pend = 1'b0;
            trig_movf = 1'b0;
            pps_movf  = 1'b0;
            trig_mq.delete();
            pps_mq.delete();
        end else begin
            // Stamp is the count during the pps_o cycle
            if (pps_pend) begin
                if (pps_mq.size() < `TURFIO_EVQ_DEPTH) pps_mq.push_back(m_count[15:0]);
                else pps_movf = 1'b1;
            end
            if (trig_pend) begin
                if (trig_mq.size() < `TURFIO_EVQ_DEPTH)
                    trig_mq.push_back({1'b0, trig_pend_time});
                else trig_movf = 1'b1;
            end
            // Count runs free unless an accepted sync presets it
            if (sync_pend && m_ctrl[16]) m_count = 48'(m_ctrl[7:0]);
            else m_count = m_count + 1'b1;
            sync_pend      = command_valid_i && command_i[31];
            pps_pend       = command_valid_i && command_i[30];
            trig_pend      = command_valid_i && command_i[15];
            trig_pend_time = command_i[14:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking and random helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input string name, input logic [63:0] act,
                               input logic [63:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED %s actual 0x%0h expected 0x%0h", name, act, exp);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic send_command(input logic [31:0] word, input logic valid);
        @(posedge sysclk_i);
        command_i       <= word;
        command_valid_i <= valid;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge sysclk_i);
            command_valid_i <= 1'b0;
        end
    endtask

    // Single Wishbone access
    // Snap holds the count sampled along with the strobe
    task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat,
                             output logic [47:0] snap);
        int waits;
        waits = 0;
        @(posedge sysclk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        wb_sel_i <= sel;
        do begin
            @(negedge sysclk_i);
            waits++;
            if (waits == 1) snap = m_count;
            if (waits > ACK_TIMEOUT) stop_run("register bus never acknowledged the access");
        end while (!wb_ack_o);
        check_equal("wb_ack_o latency", 64'(waits), 64'd2);
        rdat = wb_dat_o;
        @(posedge sysclk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        // Ack must drop after one cycle
        @(negedge sysclk_i);
        check_equal("wb_ack_o width", 64'(wb_ack_o), 64'd0);
    endtask

    task automatic check_reg(input logic [11:0] adr, input logic [31:0] exp,
                             input string name);
        logic [31:0] rd;
        logic [47:0] snap;
        bus_cycle(1'b0, adr, '0, 4'hF, rd, snap);
        check_equal({"wb_dat_o ", name}, 64'(rd), 64'(exp));
    endtask

    task automatic write_ctrl(input logic [31:0] data, input logic [3:0] sel);
        logic [31:0] rd;
        logic [47:0] snap;
        bus_cycle(1'b1, `TURFIO_REG_CTRL, data, sel, rd, snap);
        // Fields follow their byte lanes
        if (sel[0]) m_ctrl[7:0]  = data[7:0];
        if (sel[1]) m_ctrl[11:8] = data[11:8];
        if (sel[2]) m_ctrl[16]   = data[16];
    endtask

    // Expected head word carries valid and overflow
    // Model pops only after a non-empty read
    task automatic read_queue_check(input logic is_pps);
        logic [31:0] exp;
        if (is_pps) begin
            if (pps_mq.size() > 0) exp = {1'b1, pps_movf, 14'b0, pps_mq[0]};
            else exp = {1'b0, pps_movf, 30'b0};
            check_reg(`TURFIO_REG_PPS, exp, "pps queue word");
            if (pps_mq.size() > 0) begin
                void'(pps_mq.pop_front());
                pps_movf = 1'b0;
            end
        end else begin
            if (trig_mq.size() > 0) exp = {1'b1, trig_movf, 15'b0, trig_mq[0][14:0]};
            else exp = {1'b0, trig_movf, 30'b0};
            check_reg(`TURFIO_REG_TRIG, exp, "trig queue word");
            if (trig_mq.size() > 0) begin
                void'(trig_mq.pop_front());
                trig_movf = 1'b0;
            end
        end
    endtask

    // One read past the depth covers the empty case
    task automatic drain_queues();
        repeat (`TURFIO_EVQ_DEPTH + 1) read_queue_check(1'b0);
        repeat (`TURFIO_EVQ_DEPTH + 1) read_queue_check(1'b1);
    endtask

    // Upper half comes from the shadow taken by the low read
    task automatic check_count();
        logic [31:0] rd;
        logic [47:0] snap;
        logic [47:0] dummy;
        bus_cycle(1'b0, `TURFIO_REG_COUNT_LO, '0, 4'hF, rd, snap);
        check_equal("wb_dat_o count_lo", 64'(rd), 64'(snap[31:0]));
        bus_cycle(1'b0, `TURFIO_REG_COUNT_HI, '0, 4'hF, rd, dummy);
        check_equal("wb_dat_o count_hi", 64'(rd), 64'(snap[47:32]));
    endtask

    task automatic pulse_pps();
        send_command(32'h4000_0000, 1'b1);
        idle_cycles(1);
        @(negedge sysclk_i);
        check_equal("pps_o", 64'(pps_o), 64'd1);
        idle_cycles(1);
        @(negedge sysclk_i);
        check_equal("pps_o", 64'(pps_o), 64'd0);
    endtask

    // Command sampled one edge after drive and phase reset one edge later
    task automatic check_sync_realign(input logic [3:0] s);
        send_command(32'h8000_0000, 1'b1);
        for (int j = 1; j <= 43; j++) begin
            @(posedge sysclk_i);
            command_i       <= '0;
            command_valid_i <= 1'b0;
            @(negedge sysclk_i);
            if (j >= 3) check_equal("sync_o", 64'(sync_o), 64'(((j - 3) % 16) == int'(s)));
        end
    endtask

    // Ignored sync keeps the running 16 cycle period
    task automatic check_sync_unchanged();
        int waits;
        waits = 0;
        do begin
            @(negedge sysclk_i);
            waits++;
            if (waits > 40) stop_run("sync_o never pulsed while external sync was off");
        end while (!sync_o);
        for (int i = 1; i <= 48; i++) begin
            @(posedge sysclk_i);
            command_i       <= 32'h8000_0000;
            command_valid_i <= (i == 3);
            @(negedge sysclk_i);
            check_equal("sync_o", 64'(sync_o), 64'((i % 16) == 0));
        end
        send_command('0, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        stop_run("watchdog expired before the tests completed");
    end

    initial begin
        logic [11:0] adr;
        logic [3:0]  s;
        logic [7:0]  off;
        int          n;

        lfsr_q          = 32'd74102;
        sysclk_i        = 1'b0;
        rst_n_i         = 1'b0;
        wb_cyc_i        = 1'b0;
        wb_stb_i        = 1'b0;
        wb_we_i         = 1'b0;
        wb_adr_i        = '0;
        wb_dat_i        = '0;
        wb_sel_i        = '0;
        command_i       = '0;
        command_valid_i = 1'b0;

        repeat (RESET_CYCLES) @(posedge sysclk_i);
        rst_n_i <= 1'b1;
        @(negedge sysclk_i);
        check_equal("wb_ack_o", 64'(wb_ack_o), 64'd0);
        check_equal("sync_o", 64'(sync_o), 64'd0);
        check_equal("pps_o", 64'(pps_o), 64'd0);
        check_reg(`TURFIO_REG_CTRL, 32'd0, "ctrl after reset");
        check_count();

        // Identification, control readback, unmapped space
        check_reg(`TURFIO_REG_IDENT, "TFIO", "ident");
        check_reg(`TURFIO_REG_VERSION, `TURFIO_DATEVERSION, "version");
        for (int i = 0; i < N_CTRL; i++) begin
            write_ctrl(rand_bits(32), 4'(rand_bits(4)));
            check_reg(`TURFIO_REG_CTRL, m_ctrl, "ctrl readback");
        end
        for (int i = 0; i < N_UNMAPPED; i++) begin
            adr = {10'(rand_bits(10)), 2'b00};
            if (adr < 12'h020) adr = adr | 12'h800;
            check_reg(adr, 32'd0, "unmapped read");
        end
        write_ctrl(32'd0, 4'hF);

        // Trigger queue fed random words with some invalid cycles
        for (int r = 0; r < N_TRIG_ROUNDS; r++) begin
            n = 1 + rand_bits(3);
            for (int k = 0; k < n; k++) begin
                send_command(rand_bits(32) | 32'h0000_8000, rand_bits(2) != 0);
                idle_cycles(rand_bits(2));
            end
            idle_cycles(3);
            drain_queues();
        end
        // Six back to back overflow the queue by two
        repeat (6) send_command(32'h0000_8000 | rand_bits(15), 1'b1);
        idle_cycles(3);
        drain_queues();

        // PPS queue stamps spread by random gaps
        for (int r = 0; r < N_PPS_ROUNDS; r++) begin
            n = 1 + rand_bits(3);
            for (int k = 0; k < n; k++) begin
                send_command(32'h4000_0000 | (rand_bits(32) & 32'h3FFF_7FFF), 1'b1);
                idle_cycles(rand_bits(3));
            end
            idle_cycles(3);
            drain_queues();
        end

        // External sync with random phase and count preset
        for (int r = 0; r < N_SYNC_ROUNDS; r++) begin
            s   = 4'(rand_bits(4));
            off = 8'(rand_bits(8));
            write_ctrl({15'b0, 1'b1, 4'b0, s, off}, 4'b0111);
            check_sync_realign(s);
            check_count();
            pulse_pps();
            idle_cycles(2);
            drain_queues();
            idle_cycles(rand_bits(3));
            check_count();
        end

        // Count keeps running with sync disabled
        s   = 4'(rand_bits(4));
        off = 8'(rand_bits(8));
        write_ctrl({20'b0, s, off}, 4'b0111);
        check_sync_unchanged();
        check_count();

        $display("test passed");
        $finish;
    end

endmodule

/* hw/turfio_cmd_decoder.sv */
`include "turfio_defs.svh"

module turfio_cmd_decoder (
    input  logic                       sysclk_i,
    input  logic                       rst_n_i,
    // TURF command word
    input  logic [`TURFIO_CMD_W-1:0]   command_i,
    input  logic                       command_valid_i,
    // Decoded strobes, one cycle after the command
    output logic                       sync_req_o,
    output logic                       pps_o,
    output logic                       trig_push_o,
    output turfio_pkg::trig_time_t     trig_time_o
);
    localparam int TT_W = $bits(turfio_pkg::trig_time_t);

    logic cmd_sync;
    logic cmd_pps;
    logic cmd_trig;

    // Fields only count in a valid cycle
    assign cmd_sync = command_valid_i && command_i[`TURFIO_CMD_SYNC_BIT];
    assign cmd_pps  = command_valid_i && command_i[`TURFIO_CMD_PPS_BIT];
    assign cmd_trig = command_valid_i && command_i[`TURFIO_CMD_TRIG_BIT];

    // Strobes
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_req_o  <= 1'b0;
            pps_o       <= 1'b0;
            trig_push_o <= 1'b0;
        end else begin
            sync_req_o  <= cmd_sync;
            pps_o       <= cmd_pps;
            trig_push_o <= cmd_trig;
        end
    end

    // Trigger time held until the next trigger
    always_ff @(posedge sysclk_i) begin
        if (cmd_trig) trig_time_o <= command_i[TT_W-1:0];
    end

    // Every strobe traces back to a valid word
    a_strobe_from_valid: assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i)
        (sync_req_o || pps_o || trig_push_o) |-> $past(command_valid_i)
    );

endmodule

/* hw/turfio_core.sv */
`include "turfio_defs.svh"

module turfio_core (
    input  logic                           sysclk_i,
    input  logic                           rst_n_i,
    // Wishbone classic slave
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [`TURFIO_WB_ADR_W-1:0]    wb_adr_i,
    input  logic [`TURFIO_WB_DAT_W-1:0]    wb_dat_i,
    input  logic [`TURFIO_WB_DAT_W/8-1:0]  wb_sel_i,
    output logic                           wb_ack_o,
    output logic [`TURFIO_WB_DAT_W-1:0]    wb_dat_o,
    // TURF command path
    input  logic [`TURFIO_CMD_W-1:0]       command_i,
    input  logic                           command_valid_i,
    output logic                           sync_o,
    output logic                           pps_o
);
    logic                    sync_req;
    logic                    trig_push;
    turfio_pkg::trig_time_t  trig_time;
    turfio_pkg::pps_stamp_t  pps_stamp;

    // Control fields down, count back up
    turfio_sync_if sync_bus ();
    // One port per queue, typed by its payload
    turfio_evq_if #(.payload_t(turfio_pkg::trig_time_t)) trig_evq ();
    turfio_evq_if #(.payload_t(turfio_pkg::pps_stamp_t)) pps_evq ();

    //////////////////////////////////////////////////////////////////////
    // Register slave
    //////////////////////////////////////////////////////////////////////

    turfio_regctrl i_regctrl (
        .sysclk_i (sysclk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .sync_if  (sync_bus.ctrl),
        .trig_q   (trig_evq.reader),
        .pps_q    (pps_evq.reader)
    );

    //////////////////////////////////////////////////////////////////////
    // Command path, counters and event queues
    //////////////////////////////////////////////////////////////////////

    turfio_cmd_decoder i_cmd_dec (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .command_i       (command_i),
        .command_valid_i (command_valid_i),
        .sync_req_o      (sync_req),
        .pps_o           (pps_o),
        .trig_push_o     (trig_push),
        .trig_time_o     (trig_time)
    );

    turfio_sync_counter i_sync_cnt (
        .sysclk_i    (sysclk_i),
        .rst_n_i     (rst_n_i),
        .sync_req_i  (sync_req),
        .sync_o      (sync_o),
        .pps_stamp_o (pps_stamp),
        .sync_if     (sync_bus.counter)
    );

    turfio_event_queue #(.payload_t(turfio_pkg::trig_time_t)) i_trig_q (
        .sysclk_i (sysclk_i),
        .rst_n_i  (rst_n_i),
        .push_i   (trig_push),
        .data_i   (trig_time),
        .q        (trig_evq.writer)
    );

    // Stamp taken in the same cycle as the PPS strobe
    turfio_event_queue #(.payload_t(turfio_pkg::pps_stamp_t)) i_pps_q (
        .sysclk_i (sysclk_i),
        .rst_n_i  (rst_n_i),
        .push_i   (pps_o),
        .data_i   (pps_stamp),
        .q        (pps_evq.writer)
    );

endmodule

/* hw/turfio_defs.svh */
`ifndef TURFIO_DEFS_SVH
`define TURFIO_DEFS_SVH

// Register bus widths, byte addressed
`define TURFIO_WB_ADR_W     12
`define TURFIO_WB_DAT_W     32

// TURF command word and its fields
`define TURFIO_CMD_W        32
`define TURFIO_CMD_SYNC_BIT 31
`define TURFIO_CMD_PPS_BIT  30
`define TURFIO_CMD_TRIG_BIT 15

// Free running clock counter
`define TURFIO_COUNT_W      48

// Entries per event queue
`define TURFIO_EVQ_DEPTH    4

// "TFIO" in ASCII
`define TURFIO_IDENT        32'h5446_494F
// Build code in upper half, then major, minor, revision
`define TURFIO_DATEVERSION  32'h2E1C_040F

// Register map, word aligned byte offsets
`define TURFIO_REG_IDENT    12'h000
`define TURFIO_REG_VERSION  12'h004
`define TURFIO_REG_CTRL     12'h008
`define TURFIO_REG_COUNT_LO 12'h00C
`define TURFIO_REG_COUNT_HI 12'h010
`define TURFIO_REG_TRIG     12'h014
`define TURFIO_REG_PPS      12'h018

`endif

/* hw/turfio_event_queue.sv */
`include "turfio_defs.svh"

module turfio_event_queue #(
    parameter type payload_t = logic
) (
    input  logic           sysclk_i,
    input  logic           rst_n_i,
    // Producer side, no back-pressure
    input  logic           push_i,
    input  payload_t       data_i,
    // Head, flags and pop toward the register slave
    turfio_evq_if.writer   q
);
    localparam int DEPTH = `TURFIO_EVQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               overflow_q;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == (PTR_W+1)'(DEPTH));
    assign do_pop  = q.pop && (count != '0);
    // Full queue still takes a push when the head leaves
    assign do_push = push_i && (!full || do_pop);

    // Pointers, count and sticky overflow
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Dropped push, then cleared by the reading pop
            if (push_i && !do_push) overflow_q <= 1'b1;
            else if (q.pop)         overflow_q <= 1'b0;
        end
    end

    // Storage
    always_ff @(posedge sysclk_i) begin
        if (do_push) mem[wr_ptr] <= data_i;
    end

    assign q.valid    = (count != '0);
    assign q.data     = mem[rd_ptr];
    assign q.overflow = overflow_q;

    a_count_bound: assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i)
        count <= (PTR_W+1)'(DEPTH)
    );

    // Reader only pops a non-empty queue
    a_pop_when_valid: assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i)
        q.pop |-> q.valid
    );

endmodule

/* hw/turfio_if.sv */
// Event queue port between a queue and the register slave
interface turfio_evq_if #(
    parameter type payload_t = logic
);
    // Drop the head entry, one cycle
    logic     pop;
    // Queue holds at least one entry
    logic     valid;
    // Head entry
    payload_t data;
    // Sticky, a push was lost
    logic     overflow;

    // Register slave side
    modport reader (
        output pop,
        input  valid,
        input  data,
        input  overflow
    );

    // Queue side
    modport writer (
        input  pop,
        output valid,
        output data,
        output overflow
    );
endinterface

// Control fields to the sync counter and count back
interface turfio_sync_if;
    turfio_pkg::sync_offset_t  sync_offset;
    turfio_pkg::clock_offset_t clock_offset;
    logic                      en_ext_sync;
    turfio_pkg::sysclk_count_t sysclk_count;

    modport ctrl (
        output sync_offset,
        output clock_offset,
        output en_ext_sync,
        input  sysclk_count
    );

    modport counter (
        input  sync_offset,
        input  clock_offset,
        input  en_ext_sync,
        output sysclk_count
    );
endinterface

/* hw/turfio_pkg.sv */
`include "turfio_defs.svh"

package turfio_pkg;

    //////////////////////////////////////////////////////////////////////
    // Event payloads
    //////////////////////////////////////////////////////////////////////

    // Trigger time carried in the low bits of a trigger command
    typedef logic [14:0] trig_time_t;

    // Low bits of the clock counter at a PPS
    typedef logic [15:0] pps_stamp_t;

    //////////////////////////////////////////////////////////////////////
    // Sync and clock counting
    //////////////////////////////////////////////////////////////////////

    // Phase within the 16 cycle period where sync fires
    typedef logic [3:0] sync_offset_t;

    // Value loaded into the clock counter on external sync
    typedef logic [7:0] clock_offset_t;

    // Full width clock counter
    typedef logic [`TURFIO_COUNT_W-1:0] sysclk_count_t;

endpackage

/* hw/turfio_regctrl.sv */
`include "turfio_defs.svh"

module turfio_regctrl (
    input  logic                           sysclk_i,
    input  logic                           rst_n_i,
    // Wishbone classic slave
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [`TURFIO_WB_ADR_W-1:0]    wb_adr_i,
    input  logic [`TURFIO_WB_DAT_W-1:0]    wb_dat_i,
    input  logic [`TURFIO_WB_DAT_W/8-1:0]  wb_sel_i,
    output logic                           wb_ack_o,
    output logic [`TURFIO_WB_DAT_W-1:0]    wb_dat_o,
    // Counter control and the two queue heads
    turfio_sync_if.ctrl                    sync_if,
    turfio_evq_if.reader                   trig_q,
    turfio_evq_if.reader                   pps_q
);
    // Payload bits below valid and overflow
    localparam int QW   = `TURFIO_WB_DAT_W - 2;
    // Count bits above the low word
    localparam int HI_W = `TURFIO_COUNT_W - 32;

    logic [`TURFIO_WB_ADR_W-1:0]  adr_word;
    logic                         bus_req;
    logic                         rd_req;
    logic                         wr_ctrl;
    logic [`TURFIO_WB_DAT_W-1:0]  ctrl_word;
    logic [`TURFIO_WB_DAT_W-1:0]  trig_word;
    logic [`TURFIO_WB_DAT_W-1:0]  pps_word;
    logic [`TURFIO_WB_DAT_W-1:0]  rd_data;
    logic [HI_W-1:0]              count_hi_q;
    turfio_pkg::clock_offset_t    clock_offset_q;
    turfio_pkg::sync_offset_t     sync_offset_q;
    logic                         en_ext_sync_q;

    //////////////////////////////////////////////////////////////////////
    // Bus handshake
    //////////////////////////////////////////////////////////////////////

    // Byte lanes ignored in decode
    assign adr_word = {wb_adr_i[`TURFIO_WB_ADR_W-1:2], 2'b00};
    // New request, ack not yet given
    assign bus_req  = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign rd_req   = bus_req && !wb_we_i;
    assign wr_ctrl  = bus_req && wb_we_i && (adr_word == `TURFIO_REG_CTRL);

    // Single cycle ack, one cycle after the strobe
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= bus_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control register
    //////////////////////////////////////////////////////////////////////

    // Each field updates only under its own byte lane
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            clock_offset_q <= '0;
            sync_offset_q  <= '0;
            en_ext_sync_q  <= 1'b0;
        end else if (wr_ctrl) begin
            if (wb_sel_i[0]) clock_offset_q <= wb_dat_i[7:0];
            if (wb_sel_i[1]) sync_offset_q  <= wb_dat_i[11:8];
            if (wb_sel_i[2]) en_ext_sync_q  <= wb_dat_i[16];
        end
    end

    assign sync_if.clock_offset = clock_offset_q;
    assign sync_if.sync_offset  = sync_offset_q;
    assign sync_if.en_ext_sync  = en_ext_sync_q;

    //////////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl_word        = '0;
        ctrl_word[7:0]   = clock_offset_q;
        ctrl_word[11:8]  = sync_offset_q;
        ctrl_word[16]    = en_ext_sync_q;
    end

    // Valid, overflow, then head entry or zero when empty
    assign trig_word = {trig_q.valid, trig_q.overflow,
                        trig_q.valid ? QW'(trig_q.data) : QW'(0)};
    assign pps_word  = {pps_q.valid, pps_q.overflow,
                        pps_q.valid ? QW'(pps_q.data) : QW'(0)};

    always_comb begin
        case (adr_word)
            `TURFIO_REG_IDENT:    rd_data = `TURFIO_IDENT;
            `TURFIO_REG_VERSION:  rd_data = `TURFIO_DATEVERSION;
            `TURFIO_REG_CTRL:     rd_data = ctrl_word;
            `TURFIO_REG_COUNT_LO: rd_data = sync_if.sysclk_count[31:0];
            `TURFIO_REG_COUNT_HI: rd_data = `TURFIO_WB_DAT_W'(count_hi_q);
            `TURFIO_REG_TRIG:     rd_data = trig_word;
            `TURFIO_REG_PPS:      rd_data = pps_word;
            // Unmapped reads back zero
            default:              rd_data = '0;
        endcase
    end

    // Read word and upper count captured at the strobe
    always_ff @(posedge sysclk_i) begin
        if (rd_req) wb_dat_o <= rd_data;
        if (rd_req && (adr_word == `TURFIO_REG_COUNT_LO)) begin
            count_hi_q <= sync_if.sysclk_count[`TURFIO_COUNT_W-1:32];
        end
    end

    // Pop lands with the ack, so the head was already sampled
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trig_q.pop <= 1'b0;
            pps_q.pop  <= 1'b0;
        end else begin
            trig_q.pop <= rd_req && (adr_word == `TURFIO_REG_TRIG) && trig_q.valid;
            pps_q.pop  <= rd_req && (adr_word == `TURFIO_REG_PPS) && pps_q.valid;
        end
    end

    // Master must hold the cycle until it sees ack
    a_ack_in_cycle: assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i)
    );

endmodule

/* hw/turfio_sync_counter.sv */
module turfio_sync_counter (
    input  logic                    sysclk_i,
    input  logic                    rst_n_i,
    // Sync request from the command decoder
    input  logic                    sync_req_i,
    output logic                    sync_o,
    // Count snapshot for the PPS queue
    output turfio_pkg::pps_stamp_t  pps_stamp_o,
    turfio_sync_if.counter          sync_if
);
    localparam int STAMP_W = $bits(turfio_pkg::pps_stamp_t);

    turfio_pkg::sync_offset_t  phase_q;
    turfio_pkg::sysclk_count_t count_q;
    logic                      ext_sync;

    // Requests ignored unless external sync is enabled
    assign ext_sync = sync_req_i && sync_if.en_ext_sync;

    //////////////////////////////////////////////////////////////////////
    // Phase and clock counters
    //////////////////////////////////////////////////////////////////////

    // Phase wraps every 16 cycles on its own width
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= '0;
            count_q <= '0;
        end else if (ext_sync) begin
            // Realign phase and preset the count
            phase_q <= '0;
            count_q <= turfio_pkg::sysclk_count_t'(sync_if.clock_offset);
        end else begin
            phase_q <= phase_q + 1'b1;
            count_q <= count_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sync output
    //////////////////////////////////////////////////////////////////////

    // Compare is registered, so sync lags the phase match by one
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_o <= 1'b0;
        end else begin
            sync_o <= (phase_q == sync_if.sync_offset);
        end
    end

    assign sync_if.sysclk_count = count_q;
    // Low count bits, pushed with the PPS strobe
    assign pps_stamp_o          = count_q[STAMP_W-1:0];

endmodule

/* turfio_core.f */
+incdir+hw
hw/turfio_pkg.sv
hw/turfio_if.sv
hw/turfio_regctrl.sv
hw/turfio_cmd_decoder.sv
hw/turfio_sync_counter.sv
hw/turfio_event_queue.sv
hw/turfio_core.sv
bench/tb_turfio_core.sv
